// File: project.f
+incdir+rtl
rtl/fetch_pkg.sv
rtl/fetch_icache.sv
rtl/fetch_sequencer.sv
rtl/branch_resolver.sv
rtl/fetch_unit.sv
dv/fetch_unit_assert.sv
dv/fetch_unit_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Compile and run the fetch unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f \
	--top-module fetch_unit_tb -Mdir obj_dir || { echo "Build failed"; exit 1; }

output="$(./obj_dir/Vfetch_unit_tb 2>&1)"
echo "$output"

echo "$output" | grep -qx "STATUS: PASS" && echo "Run passed" || { echo "Run failed"; exit 1; }

// File: dv/fetch_unit_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "fetch_defs.svh"

module fetch_unit_tb import fetch_pkg::*; ();

	localparam int MEM_WORDS = 64;
	localparam int LINE_COUNT = `FETCH_ICACHE_LINES;
	localparam int NUM_RETIRES = 600;
	// Twice a miss with full bus delay plus a long stall and a branch wait
	localparam int CYCLES_PER_RETIRE = 40;
	localparam int WATCHDOG_CYCLES = NUM_RETIRES * CYCLES_PER_RETIRE + 200;

	localparam logic [6:0] JAL_OPCODE = 7'b1101111;
	localparam logic [6:0] BRANCH_OPCODE = 7'b1100011;
	localparam logic [6:0] OP_IMM_OPCODE = 7'b0010011;

	logic i_clock;
	logic i_reset;
	logic i_stall;
	logic i_branch_taken;
	logic o_bus_request;
	fetch_addr_t o_bus_address;
	logic i_bus_ready;
	fetch_word_t i_bus_rdata;
	logic o_retire_valid;
	fetch_addr_t o_retire_pc;
	fetch_word_t o_retire_instruction;

	integer seed = 32'hce7e;

	fetch_word_t program_memory [MEM_WORDS];

	// Shadow of the cache contents that each bus transfer fills
	logic model_valid [LINE_COUNT];
	fetch_addr_t model_address [LINE_COUNT];

	int retire_count = 0;
	int jal_count = 0;
	int taken_count = 0;
	int not_taken_count = 0;
	int fill_count = 0;
	int retire_error_count = 0;
	int bus_error_count = 0;
	int end_error_count = 0;
	logic timed_out = 1'b0;

	fetch_unit i_fetch_unit (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_stall(i_stall),
		.i_branch_taken(i_branch_taken),
		.o_bus_request(o_bus_request),
		.o_bus_address(o_bus_address),
		.i_bus_ready(i_bus_ready),
		.i_bus_rdata(i_bus_rdata),
		.o_retire_valid(o_retire_valid),
		.o_retire_pc(o_retire_pc),
		.o_retire_instruction(o_retire_instruction)
	);

	bind fetch_icache fetch_unit_assert i_protocol_assert (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_request_tag(i_request_tag),
		.i_response_tag(o_response_tag),
		.i_bus_request(o_bus_request),
		.i_bus_address(o_bus_address),
		.i_bus_ready(i_bus_ready)
	);

	initial begin : clock_gen
		i_clock = 1'b0;
		forever #10 i_clock = ~i_clock;
	end

	function automatic logic [31:0] encode_jal(input logic [31:0] offset, input logic [4:0] rd);
		return {offset[20], offset[10:1], offset[11], offset[19:12], rd, JAL_OPCODE};
	endfunction

	// Fields hold rs2, rs1 and funct3
	function automatic logic [31:0] encode_branch(input logic [31:0] offset,
			input logic [12:0] fields);
		return {offset[12], offset[10:5], fields, offset[4:1], offset[11], BRANCH_OPCODE};
	endfunction

	// Next PC as the RV32I rules for JAL and conditional branches give it
	function automatic logic [31:0] reference_next_pc(input logic [31:0] pc,
			input logic [31:0] instruction, input logic taken);
		logic [31:0] j_imm;
		logic [31:0] b_imm;
		j_imm = {{12{instruction[31]}}, instruction[19:12], instruction[20],
			instruction[30:21], 1'b0};
		b_imm = {{20{instruction[31]}}, instruction[7], instruction[30:25],
			instruction[11:8], 1'b0};
		case (instruction[6:0])
			JAL_OPCODE: return pc + j_imm;
			BRANCH_OPCODE: return taken ? pc + b_imm : pc + 32'd4;
			default: return pc + 32'd4;
		endcase
	endfunction

	task automatic fill_program;
		logic [31:0] rand_word;
		int index;
		int step;
		int target;
		for (index = 0; index < MEM_WORDS - 1; index++) begin
			rand_word = $random(seed);
			step = int'(rand_word & 32'd7) + 1;
			case (rand_word[6:4])
				3'd0: begin
					// Forward jumps only so that no loop is unconditional
					target = index + step;
					if (target > MEM_WORDS - 1) begin
						target = MEM_WORDS - 1;
					end
					program_memory[index] = encode_jal((target - index) * 4, rand_word[11:7]);
				end
				3'd1: begin
					target = rand_word[3] ? index - step : index + step;
					if (target < 0 || target > MEM_WORDS - 1) begin
						target = 2 * index - target;
					end
					program_memory[index] = encode_branch((target - index) * 4, rand_word[31:19]);
				end
				default: begin
					program_memory[index] = rand_word;
					if (rand_word[6:0] == JAL_OPCODE || rand_word[6:0] == BRANCH_OPCODE) begin
						program_memory[index][6:0] = OP_IMM_OPCODE;
					end
				end
			endcase
		end
		// Last word wraps the program back to the start
		program_memory[MEM_WORDS-1] = encode_jal(-(MEM_WORDS - 1) * 4, 5'd0);
	endtask

	task automatic report_and_finish;
		int total_errors;
		total_errors = retire_error_count + bus_error_count + end_error_count;
		$write("Retired %0d (%0d JAL, %0d taken, %0d not taken), %0d bus fills, ",
			retire_count, jal_count, taken_count, not_taken_count, fill_count);
		$display("errors: retire %0d, bus %0d, end %0d", retire_error_count, bus_error_count,
			end_error_count);
		if (total_errors == 0 && !timed_out) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	endtask

	initial begin : main_sequence
		i_reset = 1'b1;
		fill_program();
		repeat (5) @(negedge i_clock);
		i_reset = 1'b0;
		wait (retire_count >= NUM_RETIRES);
		@(negedge i_clock);
		assert (jal_count > 0 && taken_count > 0 && not_taken_count > 0) else begin
			end_error_count++;
			$display("Not every kind of JAL and branch outcome was retired");
		end
		assert (fill_count < retire_count) else begin
			end_error_count++;
			$display("No retired instruction was served from the cache");
		end
		report_and_finish();
	end

	initial begin : stall_and_branch_drive
		logic [31:0] rand_word;
		logic [3:0] stall_left;
		i_stall = 1'b0;
		i_branch_taken = 1'b0;
		stall_left = '0;
		forever begin
			@(negedge i_clock);
			rand_word = $random(seed);
			i_branch_taken = rand_word[0];
			if (stall_left != 4'd0) begin
				stall_left = stall_left - 4'd1;
				i_stall = 1'b1;
			end else if (rand_word[7:4] == 4'd0) begin
				// Stretch of 1 to 8 cycles
				stall_left = {1'b0, rand_word[10:8]};
				i_stall = 1'b1;
			end else begin
				i_stall = 1'b0;
			end
		end
	end

	initial begin : bus_memory_model
		logic [31:0] rand_word;
		int line;
		i_bus_ready = 1'b0;
		i_bus_rdata = '0;
		for (line = 0; line < LINE_COUNT; line++) begin
			model_valid[line] = 1'b0;
		end
		forever begin
			@(negedge i_clock);
			if (o_bus_request === 1'b1) begin
				rand_word = $random(seed);
				// 0 to 3 cycles before ready
				repeat (rand_word[1:0]) @(negedge i_clock);
				line = int'((o_bus_address >> 2) % LINE_COUNT);
				assert (!(model_valid[line] && model_address[line] == o_bus_address)) else begin
					bus_error_count++;
					$display("Bus fill for address 0x%08h that is already cached", o_bus_address);
				end
				assert (o_bus_address < MEM_WORDS * 4) else begin
					bus_error_count++;
					$display("Bus address 0x%08h is outside program memory", o_bus_address);
				end
				model_valid[line] = 1'b1;
				model_address[line] = o_bus_address;
				fill_count++;
				i_bus_rdata = program_memory[o_bus_address[7:2]];
				i_bus_ready = 1'b1;
				@(negedge i_clock);
				i_bus_ready = 1'b0;
			end
		end
	end

	initial begin : retire_check
		fetch_addr_t expected_pc;
		fetch_word_t expected_instruction;
		logic taken_at_pulse;
		expected_pc = `FETCH_RESET_PC;
		taken_at_pulse = 1'b0;
		forever begin
			@(posedge i_clock);
			if (i_reset === 1'b0 && o_retire_valid === 1'b1) begin
				expected_instruction = program_memory[expected_pc[7:2]];
				assert (o_retire_pc == expected_pc) else begin
					retire_error_count++;
					$display("Error: o_retire_pc 0x%08h, expected 0x%08h", o_retire_pc, expected_pc);
				end
				assert (o_retire_instruction == expected_instruction) else begin
					retire_error_count++;
					$display("Error: o_retire_instruction 0x%08h, expected 0x%08h",
						o_retire_instruction, expected_instruction);
				end
				if (expected_instruction[6:0] == JAL_OPCODE) begin
					jal_count++;
				end else if (expected_instruction[6:0] == BRANCH_OPCODE) begin
					if (taken_at_pulse) begin
						taken_count++;
					end else begin
						not_taken_count++;
					end
				end
				expected_pc = reference_next_pc(expected_pc, expected_instruction, taken_at_pulse);
				retire_count++;
			end
			// Taken level seen by the resolver at the edge that starts the pulse
			taken_at_pulse = i_branch_taken;
		end
	end

	initial begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge i_clock);
		timed_out = 1'b1;
		$display("Timeout: only %0d of %0d instructions retired in %0d cycles",
			retire_count, NUM_RETIRES, WATCHDOG_CYCLES);
		report_and_finish();
	end

endmodule

`default_nettype wire

// File: dv/fetch_unit_assert.sv
`timescale 1ns/10ps
`default_nettype none

// Bus and tag protocol checks on the instruction cache
module fetch_unit_assert import fetch_pkg::*; (
	input wire logic i_clock,
	input wire logic i_reset,
	input wire fetch_tag_t i_request_tag,
	input wire fetch_tag_t i_response_tag,
	input wire logic i_bus_request,
	input wire fetch_addr_t i_bus_address,
	input wire logic i_bus_ready
);

	// Request waits with a fixed address until ready
	property bus_request_held;
		@(posedge i_clock) disable iff (i_reset)
		(i_bus_request && !i_bus_ready) |=> (i_bus_request && $stable(i_bus_address));
	endproperty

	// Released at the ready edge
	property bus_request_released;
		@(posedge i_clock) disable iff (i_reset)
		(i_bus_request && i_bus_ready) |=> !i_bus_request;
	endproperty

	// The response tag only catches up with a request tag that held still
	property response_tag_follows_request;
		@(posedge i_clock) disable iff (i_reset)
		!$stable(i_response_tag) |->
			(i_response_tag == $past(i_request_tag)) && $stable(i_request_tag);
	endproperty

	assert property (bus_request_held)
		else $error("Bus request dropped or its address moved before ready");
	assert property (bus_request_released)
		else $error("Bus request still high after ready was seen");
	assert property (response_tag_follows_request)
		else $error("Response tag changed to a value other than the request tag");

endmodule

`default_nettype wire

// File: rtl/fetch_unit.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_unit import fetch_pkg::*; (
	input wire logic i_clock,
	input wire logic i_reset,
	input wire logic i_stall,
	input wire logic i_branch_taken,

	// Memory bus
	output logic o_bus_request,
	output fetch_addr_t o_bus_address,
	input wire logic i_bus_ready,
	input wire fetch_word_t i_bus_rdata,

	// Retire stream
	output logic o_retire_valid,
	output fetch_addr_t o_retire_pc,
	output fetch_word_t o_retire_instruction
);

	// Sequencer and cache
	fetch_tag_t request_tag;
	fetch_addr_t request_address;
	fetch_tag_t response_tag;
	fetch_word_t response_data;

	// Sequencer and resolver
	fetch_tag_t fetch_tag;
	fetch_word_t fetch_instruction;
	fetch_addr_t fetch_pc;
	fetch_tag_t resolve_tag;
	fetch_addr_t resolve_pc_next;

	fetch_sequencer i_fetch_sequencer (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_stall(i_stall),
		.i_resolve_tag(resolve_tag),
		.i_resolve_pc_next(resolve_pc_next),
		.o_request_tag(request_tag),
		.o_request_address(request_address),
		.i_response_tag(response_tag),
		.i_response_data(response_data),
		.o_fetch_tag(fetch_tag),
		.o_fetch_instruction(fetch_instruction),
		.o_fetch_pc(fetch_pc)
	);

	fetch_icache i_fetch_icache (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_request_tag(request_tag),
		.i_request_address(request_address),
		.o_response_tag(response_tag),
		.o_response_data(response_data),
		.o_bus_request(o_bus_request),
		.o_bus_address(o_bus_address),
		.i_bus_ready(i_bus_ready),
		.i_bus_rdata(i_bus_rdata)
	);

	branch_resolver i_branch_resolver (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_fetch_tag(fetch_tag),
		.i_fetch_instruction(fetch_instruction),
		.i_fetch_pc(fetch_pc),
		.i_branch_taken(i_branch_taken),
		.o_resolve_tag(resolve_tag),
		.o_resolve_pc_next(resolve_pc_next),
		.o_retire_valid(o_retire_valid),
		.o_retire_pc(o_retire_pc),
		.o_retire_instruction(o_retire_instruction)
	);

endmodule

`default_nettype wire

// File: rtl/branch_resolver.sv
`timescale 1ns/10ps
`default_nettype none

module branch_resolver import fetch_pkg::*; (
	input wire logic i_clock,
	input wire logic i_reset,

	// Instruction from the sequencer, new when the tag changes
	input wire fetch_tag_t i_fetch_tag,
	input wire fetch_word_t i_fetch_instruction,
	input wire fetch_addr_t i_fetch_pc,

	// Stand-in for the execute stage condition
	input wire logic i_branch_taken,

	// Next PC back to the sequencer
	output fetch_tag_t o_resolve_tag,
	output fetch_addr_t o_resolve_pc_next,

	// Retire stream
	output logic o_retire_valid,
	output fetch_addr_t o_retire_pc,
	output fetch_word_t o_retire_instruction
);

	fetch_tag_t last_tag;
	logic new_instruction;
	fetch_addr_t pc_next;

	assign new_instruction = (i_fetch_tag != last_tag);

	// Taken is sampled at the edge that starts the retire pulse
	always_comb begin
		if (!is_control_transfer(i_fetch_instruction)) begin
			pc_next = i_fetch_pc + 32'd4;
		end else if (i_fetch_instruction[6:0] == OPCODE_JAL) begin
			pc_next = i_fetch_pc + jal_offset(i_fetch_instruction);
		end else if (i_branch_taken) begin
			pc_next = i_fetch_pc + branch_offset(i_fetch_instruction);
		end else begin
			pc_next = i_fetch_pc + 32'd4;
		end
	end

	// The resolve tag follows every instruction, so when the sequencer
	// starts to wait on a branch it still holds the previous tag and
	// cannot match a stale value left from a wrapped tag
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			last_tag <= '0;
			o_resolve_tag <= '0;
			o_retire_valid <= 1'b0;
		end else begin
			o_retire_valid <= new_instruction;
			if (new_instruction) begin
				last_tag <= i_fetch_tag;
				o_resolve_tag <= i_fetch_tag;
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (new_instruction) begin
			o_resolve_pc_next <= pc_next;
			o_retire_pc <= i_fetch_pc;
			o_retire_instruction <= i_fetch_instruction;
		end
	end

endmodule

`default_nettype wire

// File: rtl/fetch_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

`include "fetch_defs.svh"

module fetch_sequencer import fetch_pkg::*; (
	input wire logic i_clock,
	input wire logic i_reset,
	input wire logic i_stall,

	// Branch outcome from the resolver
	input wire fetch_tag_t i_resolve_tag,
	input wire fetch_addr_t i_resolve_pc_next,

	// Instruction cache
	output fetch_tag_t o_request_tag,
	output fetch_addr_t o_request_address,
	input wire fetch_tag_t i_response_tag,
	input wire fetch_word_t i_response_data,

	// Fetched instruction towards the resolver
	output fetch_tag_t o_fetch_tag,
	output fetch_word_t o_fetch_instruction,
	output fetch_addr_t o_fetch_pc
);

	typedef enum logic [1:0] {
		SEQ_IDLE,
		SEQ_WAIT_CACHE,
		SEQ_WAIT_RESOLVE
	} seq_state_t;

	seq_state_t state;
	fetch_addr_t pc;
	logic response_ready;
	logic control_transfer;

	// The cache looks up whatever PC is current
	assign o_request_address = pc;

	assign response_ready = (i_response_tag == o_request_tag);
	assign control_transfer = is_control_transfer(i_response_data);

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= SEQ_IDLE;
			pc <= `FETCH_RESET_PC;
			o_request_tag <= '0;
			o_fetch_tag <= '0;
		end else begin
			case (state)
				SEQ_IDLE: begin
					if (!i_stall) begin
						o_request_tag <= o_request_tag + 1'b1;
						state <= SEQ_WAIT_CACHE;
					end
				end
				SEQ_WAIT_CACHE: begin
					if (response_ready) begin
						o_fetch_tag <= o_request_tag;
						pc <= pc + 32'd4;
						if (control_transfer) begin
							// Nothing more is fetched until the target is known
							state <= SEQ_WAIT_RESOLVE;
						end else if (!i_stall) begin
							// Back-to-back request for pc + 4
							o_request_tag <= o_request_tag + 1'b1;
						end else begin
							state <= SEQ_IDLE;
						end
					end
				end
				SEQ_WAIT_RESOLVE: begin
					if (i_resolve_tag == o_fetch_tag) begin
						pc <= i_resolve_pc_next;
						state <= SEQ_IDLE;
					end
				end
				default: state <= SEQ_IDLE;
			endcase
		end
	end

	// Instruction word and its address travel with the fetch tag
	always_ff @(posedge i_clock) begin
		if (state == SEQ_WAIT_CACHE && response_ready) begin
			o_fetch_instruction <= i_response_data;
			o_fetch_pc <= pc;
		end
	end

endmodule

`default_nettype wire

// File: rtl/fetch_icache.sv
`timescale 1ns/10ps
`default_nettype none

`include "fetch_defs.svh"

module fetch_icache import fetch_pkg::*; (
	input wire logic i_clock,
	input wire logic i_reset,

	// Request side, a new request is a change of tag
	input wire fetch_tag_t i_request_tag,
	input wire fetch_addr_t i_request_address,
	output fetch_tag_t o_response_tag,
	output fetch_word_t o_response_data,

	// Memory bus
	output logic o_bus_request,
	output fetch_addr_t o_bus_address,
	input wire logic i_bus_ready,
	input wire fetch_word_t i_bus_rdata
);

	localparam int INDEX_BITS = $clog2(`FETCH_ICACHE_LINES);
	localparam int LINE_TAG_BITS = 32 - 2 - INDEX_BITS;

	typedef enum logic {
		CACHE_IDLE,
		CACHE_FILL
	} cache_state_t;

	cache_state_t state;

	// Line storage
	fetch_word_t line_data [`FETCH_ICACHE_LINES];
	logic [LINE_TAG_BITS-1:0] line_tag [`FETCH_ICACHE_LINES];
	logic [`FETCH_ICACHE_LINES-1:0] line_valid;

	logic [INDEX_BITS-1:0] request_index;
	logic [LINE_TAG_BITS-1:0] request_line_tag;
	logic [INDEX_BITS-1:0] fill_index;
	logic [LINE_TAG_BITS-1:0] fill_line_tag;
	logic new_request;
	logic hit;
	logic fill_done;

	assign request_index = i_request_address[INDEX_BITS+1:2];
	assign request_line_tag = i_request_address[31:INDEX_BITS+2];

	// Bus address is held for the whole fill, so it also names the line
	assign fill_index = o_bus_address[INDEX_BITS+1:2];
	assign fill_line_tag = o_bus_address[31:INDEX_BITS+2];

	assign new_request = (i_request_tag != o_response_tag);
	assign hit = line_valid[request_index] && (line_tag[request_index] == request_line_tag);
	assign fill_done = (state == CACHE_FILL) && i_bus_ready;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= CACHE_IDLE;
			o_response_tag <= '0;
			o_bus_request <= 1'b0;
			line_valid <= '0;
		end else begin
			case (state)
				CACHE_IDLE: begin
					if (new_request) begin
						if (hit) begin
							o_response_tag <= i_request_tag;
						end else begin
							o_bus_request <= 1'b1;
							state <= CACHE_FILL;
						end
					end
				end
				CACHE_FILL: begin
					// Back in idle the same request now hits and is answered
					if (i_bus_ready) begin
						o_bus_request <= 1'b0;
						line_valid[fill_index] <= 1'b1;
						state <= CACHE_IDLE;
					end
				end
				default: state <= CACHE_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clock) begin
		if (state == CACHE_IDLE && new_request && hit) begin
			o_response_data <= line_data[request_index];
		end
		if (state == CACHE_IDLE && new_request && !hit) begin
			o_bus_address <= {i_request_address[31:2], 2'b00};
		end
		if (fill_done) begin
			line_data[fill_index] <= i_bus_rdata;
			line_tag[fill_index] <= fill_line_tag;
		end
	end

endmodule

`default_nettype wire

// File: rtl/fetch_pkg.sv
`default_nettype none

`include "fetch_defs.svh"

package fetch_pkg;

	typedef logic [`FETCH_BUS_DATA_BITS-1:0] fetch_word_t;
	typedef logic [31:0] fetch_addr_t;
	typedef logic [`FETCH_TAG_BITS-1:0] fetch_tag_t;

	// RV32I major opcodes that redirect the PC
	localparam logic [6:0] OPCODE_JAL = 7'b1101111;
	localparam logic [6:0] OPCODE_BRANCH = 7'b1100011;

	function automatic logic is_control_transfer(input fetch_word_t instruction);
		logic [6:0] opcode;
		opcode = instruction[6:0];
		return (opcode == OPCODE_JAL) || (opcode == OPCODE_BRANCH);
	endfunction

	// J-type immediate, bit 0 is always zero
	function automatic fetch_addr_t jal_offset(input fetch_word_t instruction);
		return {{11{instruction[31]}}, instruction[31], instruction[19:12],
			instruction[20], instruction[30:21], 1'b0};
	endfunction

	// B-type immediate
	function automatic fetch_addr_t branch_offset(input fetch_word_t instruction);
		return {{19{instruction[31]}}, instruction[31], instruction[7],
			instruction[30:25], instruction[11:8], 1'b0};
	endfunction

endpackage

`default_nettype wire

// File: rtl/fetch_defs.svh
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// Width of the request tags passed between the fetch blocks
// Tags wrap, so only equality is meaningful
`define FETCH_TAG_BITS 4

// Direct-mapped lines of one word each, must be a power of two
`define FETCH_ICACHE_LINES 16

// First instruction address after reset
`define FETCH_RESET_PC 32'h0000_0000

// Memory bus data path
`define FETCH_BUS_DATA_BITS 32

`endif
